// File: tb.f
+incdir+verilog
+incdir+tests
verilog/twiddle_pkg.sv
verilog/twiddle_if.sv
verilog/lane_fifo.sv
verilog/phase_divider.sv
verilog/cordic_sincos.sv
verilog/twiddle_powers.sv
verilog/twiddle_mult.sv
verilog/twiddle_stage.sv
tests/tb_twiddle_stage.sv

// File: Bender.yml
package:
  name: twiddle_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/twiddle_pkg.sv
      - verilog/twiddle_if.sv
      - verilog/lane_fifo.sv
      - verilog/phase_divider.sv
      - verilog/cordic_sincos.sv
      - verilog/twiddle_powers.sv
      - verilog/twiddle_mult.sv
      - verilog/twiddle_stage.sv
  - target: test
    include_dirs:
      - verilog
      - tests
    files:
      - tests/tb_twiddle_stage.sv

// File: tests/twiddle_model.svh
`ifndef TWIDDLE_MODEL_SVH
`define TWIDDLE_MODEL_SVH

// reference twiddle set for the item being sent, powers 1..4
coef_t w_re [1:4];
coef_t w_im [1:4];

// phase in 2^-16 turn, floor of num/den
function automatic phase_t model_phase(input frac_t num, input frac_t den);
	longint scaled;
	scaled = longint'(num) << `W_PHASE;
	return phase_t'(scaled / longint'(den));
endfunction

// sixteen bits of a wide product from lsb upward
function automatic coef_t coef_bits(input longint v, input int lsb);
	return v[lsb +: `W_COEF];
endfunction

// rotation of the gain-scaled unit vector, result into w_re[1] / w_im[1]
function automatic void model_w1(input phase_t ph);
	int x;
	int y;
	int z;
	int xs;
	x = 0;
	y = 0;
	// whole quarter turns from the top phase bits
	case (ph[`W_PHASE-1 -: 2])
		2'd0: x = `CORDIC_GAIN_INIT;
		2'd1: y = `CORDIC_GAIN_INIT;
		2'd2: x = -`CORDIC_GAIN_INIT;
		default: y = -`CORDIC_GAIN_INIT;
	endcase
	z = int'(ph[`W_PHASE-3:0]);
	for (int k = 0; k < `CORDIC_ITER; k++) begin
		xs = x;
		if (z >= 0) begin
			x = x - (y >>> k);
			y = y + (xs >>> k);
			z = z - int'(atan_table[k]);
		end else begin
			x = x + (y >>> k);
			y = y - (xs >>> k);
			z = z + int'(atan_table[k]);
		end
	end
	// exp(-j theta), sine negated
	w_re[1] = x[`W_COEF-1:0];
	y = -y;
	w_im[1] = y[`W_COEF-1:0];
endfunction

// w2 = w1^2, w3 = w1*w2, w4 = w2^2
function automatic void model_twiddles(input phase_t ph, input factor_t fac);
	longint r1;
	longint i1;
	longint r2;
	longint i2;
	model_w1(ph);
	r1 = w_re[1];
	i1 = w_im[1];
	if (fac == 3'd2) begin
		// radix 2, unity in place of w2
		w_re[2] = 16'sd16384;
		w_im[2] = '0;
	end else begin
		w_re[2] = coef_bits(r1 * r1 - i1 * i1, 14);
		// one bit lower doubles the cross term
		w_im[2] = coef_bits(r1 * i1, 13);
	end
	r2 = w_re[2];
	i2 = w_im[2];
	if (fac == 3'd2) begin
		w_re[3] = w_re[1];
		w_im[3] = w_im[1];
	end else begin
		w_re[3] = coef_bits(r1 * r2 - i1 * i2, 14);
		w_im[3] = coef_bits(r1 * i2 + i1 * r2, 14);
	end
	w_re[4] = coef_bits(r2 * r2 - i2 * i2, 14);
	w_im[4] = coef_bits(r2 * i2, 13);
endfunction

// q14 product to 18 bits, bit 13 rounds half up
function automatic sample_t model_round(input longint v);
	return sample_t'(v[31:14] + {17'd0, v[13]});
endfunction

function automatic sample_t model_lane_re(input sample_t dr, input sample_t di,
	input coef_t wr, input coef_t wi);
	return model_round(longint'(dr) * longint'(wr) - longint'(di) * longint'(wi));
endfunction

function automatic sample_t model_lane_im(input sample_t dr, input sample_t di,
	input coef_t wr, input coef_t wi);
	return model_round(longint'(dr) * longint'(wi) + longint'(di) * longint'(wr));
endfunction

`endif

// File: tests/tb_twiddle_stage.sv
`timescale 1ns/100ps
`include "twiddle_params.svh"

module tb_twiddle_stage;
	import twiddle_pkg::*;

	// strobes per test
	localparam int N_BURST = 60;
	localparam int N_GAPS = 80;
	localparam int N_FAC2 = 40;
	localparam int N_BYPASS = 40;
	localparam int N_EXTREME = 40;
	localparam int N_RESET = 50;
	localparam int N_STROBES = N_BURST + N_GAPS + N_FAC2 + N_BYPASS + N_EXTREME + N_RESET;
	localparam int WATCHDOG_NS = (N_STROBES + 100) * `TWDL_DELAY * 4;

	logic clk = 1'b0;
	logic rst_n;
	logic in_val;
	sample_t din_real [0:4];
	sample_t din_imag [0:4];
	frac_t twdl_num;
	frac_t twdl_den;
	factor_t factor;
	logic out_val;
	sample_t dout_real [0:4];
	sample_t dout_imag [0:4];

	int cycle = 0;
	int data_errors = 0;
	int strobe_errors = 0;
	int checked = 0;
	string test_name = "init";
	logic [31:0] lfsr = 32'hf0331c58;

	// arrival cycle per result and five lane values per result
	int due_q [$];
	sample_t exp_re_q [$];
	sample_t exp_im_q [$];

	`include "twiddle_model.svh"

	twiddle_stage i_dut (
		.clk(clk), .rst_n(rst_n), .in_val(in_val),
		.din_real(din_real), .din_imag(din_imag),
		.twdl_num(twdl_num), .twdl_den(twdl_den), .factor(factor),
		.out_val(out_val), .dout_real(dout_real), .dout_imag(dout_imag)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	// galois lfsr stepped once per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int b = 0; b < n; b++) begin
			fb = lfsr[0];
			lfsr = lfsr >> 1;
			if (fb)
				lfsr = lfsr ^ 32'hd0000001;
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic sample_t rand_sample();
		return sample_t'(take_bits(`W_SAMPLE));
	endfunction

	// never zero and never the bypass value
	function automatic frac_t rand_den();
		frac_t d;
		d = frac_t'(take_bits(`W_FRAC));
		if (d < 12'd4)
			d = d + 12'd4;
		return d;
	endfunction

	function automatic frac_t rand_num(input frac_t den);
		return frac_t'(take_bits(`W_FRAC) % den);
	endfunction

	// radix 2..5
	function automatic factor_t rand_factor();
		return factor_t'(take_bits(2) + 2);
	endfunction

	task automatic init_inputs();
		rst_n = 1'b0;
		in_val = 1'b0;
		twdl_num = '0;
		twdl_den = 12'd5;
		factor = 3'd5;
		for (int n = 0; n < 5; n++) begin
			din_real[n] = '0;
			din_imag[n] = '0;
		end
	endtask

	// num, den and factor hold their last value
	task automatic idle_cycle();
		@(posedge clk);
		#0.5;
		in_val = 1'b0;
		for (int n = 0; n < 5; n++) begin
			din_real[n] = '0;
			din_imag[n] = '0;
		end
	endtask

	task automatic send(input frac_t num, input frac_t den, input factor_t fac);
		@(posedge clk);
		#0.5;
		in_val = 1'b1;
		twdl_num = num;
		twdl_den = den;
		factor = fac;
		for (int n = 0; n < 5; n++) begin
			din_real[n] = rand_sample();
			din_imag[n] = rand_sample();
		end
		// lane 0 untouched in both modes
		exp_re_q.push_back(din_real[0]);
		exp_im_q.push_back(din_imag[0]);
		if (den == `BYPASS_DEN) begin
			due_q.push_back(cycle + 1);
		end else begin
			model_twiddles(model_phase(num, den), fac);
			due_q.push_back(cycle + `TWDL_DELAY);
		end
		for (int n = 1; n < 5; n++) begin
			if (den == `BYPASS_DEN) begin
				// unity twiddle returns the sample itself
				exp_re_q.push_back(din_real[n]);
				exp_im_q.push_back(din_imag[n]);
			end else begin
				exp_re_q.push_back(model_lane_re(din_real[n], din_imag[n],
					w_re[n], w_im[n]));
				exp_im_q.push_back(model_lane_im(din_real[n], din_imag[n],
					w_re[n], w_im[n]));
			end
		end
	endtask

	// wait for all results and let the valid pipe run empty
	task automatic drain();
		while (due_q.size() > 0)
			idle_cycle();
		repeat (`TWDL_DELAY + 2)
			idle_cycle();
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#0.5;
		rst_n = 1'b0;
		in_val = 1'b0;
		// in-flight items are lost
		due_q.delete();
		exp_re_q.delete();
		exp_im_q.delete();
		repeat (4) @(posedge clk);
		#0.5;
		rst_n = 1'b1;
	endtask

	task automatic check_valid(input logic expected, input logic actual);
		checked++;
		if (actual !== expected) begin
			strobe_errors++;
			if (expected)
				$display("%s: out_val missing at cycle %0d", test_name, cycle);
			else
				$display("%s: out_val high at cycle %0d with no result due",
					test_name, cycle);
		end
	endtask

	task automatic check_sample(input string port, input int lane, input sample_t expected,
		input sample_t actual);
		if (actual !== expected) begin
			data_errors++;
			$display("Fail %s %s[%0d] cycle %0d: expected %0d, actual %0d",
				test_name, port, lane, cycle, expected, actual);
		end
	endtask

	// checked mid-cycle where outputs are settled
	task automatic check_outputs();
		logic due;
		due = 1'b0;
		if (due_q.size() > 0)
			due = (due_q[0] == cycle);
		check_valid(due, out_val);
		if (due) begin
			for (int n = 0; n < 5; n++) begin
				check_sample("dout_real", n, exp_re_q[n], dout_real[n]);
				check_sample("dout_imag", n, exp_im_q[n], dout_imag[n]);
			end
			void'(due_q.pop_front());
			repeat (5) begin
				void'(exp_re_q.pop_front());
				void'(exp_im_q.pop_front());
			end
		end else begin
			// idle outputs read zero
			for (int n = 0; n < 5; n++) begin
				check_sample("dout_real", n, sample_t'(0), dout_real[n]);
				check_sample("dout_imag", n, sample_t'(0), dout_imag[n]);
			end
		end
	endtask

	always @(negedge clk) begin
		if (rst_n === 1'b1)
			check_outputs();
	end

	// back to back with one item per cycle
	task automatic run_burst();
		frac_t den;
		test_name = "burst_factor5";
		for (int i = 0; i < N_BURST; i++) begin
			den = rand_den();
			send(rand_num(den), den, 3'd5);
		end
		drain();
	endtask

	task automatic run_gaps();
		frac_t den;
		test_name = "random_gaps";
		for (int i = 0; i < N_GAPS; i++) begin
			repeat (take_bits(2))
				idle_cycle();
			den = rand_den();
			send(rand_num(den), den, rand_factor());
		end
		drain();
	endtask

	task automatic run_factor2();
		frac_t den;
		test_name = "factor2";
		for (int i = 0; i < N_FAC2; i++) begin
			repeat (take_bits(1))
				idle_cycle();
			den = rand_den();
			send(rand_num(den), den, 3'd2);
		end
		drain();
	endtask

	// den held at 3 through the drain so stale valids stay masked
	task automatic run_bypass();
		test_name = "bypass_den3";
		for (int i = 0; i < N_BYPASS; i++) begin
			repeat (take_bits(1))
				idle_cycle();
			send(frac_t'(take_bits(2) % 3), frac_t'(`BYPASS_DEN), rand_factor());
		end
		drain();
	endtask

	// zero, den-1 and the quarter points
	task automatic run_extremes();
		frac_t dens [0:7];
		frac_t nums [0:4];
		test_name = "extreme_numerators";
		dens = '{12'd4, 12'd5, 12'd7, 12'd12, 12'd64, 12'd1000, 12'd2049, 12'd4095};
		for (int i = 0; i < N_EXTREME / 5; i++) begin
			nums[0] = '0;
			nums[1] = dens[i] - 12'd1;
			nums[2] = dens[i] >> 2;
			nums[3] = dens[i] >> 1;
			nums[4] = frac_t'(int'(dens[i]) * 3 / 4);
			for (int j = 0; j < 5; j++)
				send(nums[j], dens[i], 3'd4);
		end
		drain();
	endtask

	task automatic run_reset_mid_burst();
		frac_t den;
		test_name = "reset_mid_burst";
		for (int i = 0; i < 20; i++) begin
			den = rand_den();
			send(rand_num(den), den, rand_factor());
		end
		apply_reset();
		// out_val must stay low here
		repeat (`TWDL_DELAY + 2)
			idle_cycle();
		for (int i = 0; i < N_RESET - 20; i++) begin
			den = rand_den();
			send(rand_num(den), den, rand_factor());
		end
		drain();
	endtask

	initial begin
		init_inputs();
		apply_reset();
		run_burst();
		run_gaps();
		run_factor2();
		run_bypass();
		run_extremes();
		run_reset_mid_burst();
		$display("%0d cycles checked, %0d data errors, %0d strobe errors",
			checked, data_errors, strobe_errors);
		if (data_errors == 0 && strobe_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: tests still running after %0d ns", WATCHDOG_NS);
		$display("Regression failed");
		$finish;
	end

endmodule

// File: verilog/twiddle_stage.sv
`timescale 1ns/100ps
`include "twiddle_params.svh"

module twiddle_stage (
	input logic clk,
	input logic rst_n,
	input logic in_val,
	input twiddle_pkg::sample_t din_real [0:4],
	input twiddle_pkg::sample_t din_imag [0:4],
	input twiddle_pkg::frac_t twdl_num,
	input twiddle_pkg::frac_t twdl_den,
	input twiddle_pkg::factor_t factor,
	output logic out_val,
	output twiddle_pkg::sample_t dout_real [0:4],
	output twiddle_pkg::sample_t dout_imag [0:4]
);
	import twiddle_pkg::*;

	phase_t phase;
	factor_t fac_div, fac_cordic;
	coef_t w1_real, w1_imag;
	logic fifo_rd, fifo_clr;
	sample_t fifo_q_real [0:4];
	sample_t fifo_q_imag [0:4];

	twiddle_if coeff_if ();

	// lane samples wait here while the twiddle is computed
	genvar i;
	generate
		for (i = 0; i < 5; i++) begin : g_lane
			sample_t wdata [0:1];
			sample_t rdata [0:1];
			assign wdata[0] = din_real[i];
			assign wdata[1] = din_imag[i];
			assign fifo_q_real[i] = rdata[0];
			assign fifo_q_imag[i] = rdata[1];

			lane_fifo u_fifo (
				.clk(clk), .rst_n(rst_n), .wr(in_val), .wdata(wdata),
				.rd(fifo_rd), .clr(fifo_clr), .rdata(rdata)
			);
		end
	endgenerate

	phase_divider u_div (
		.clk(clk), .rst_n(rst_n), .num(twdl_num), .den(twdl_den),
		.factor_in(factor), .phase(phase), .factor_out(fac_div)
	);

	cordic_sincos u_cordic (
		.clk(clk), .rst_n(rst_n), .phase(phase), .factor_in(fac_div),
		.factor_out(fac_cordic), .w1_real(w1_real), .w1_imag(w1_imag)
	);

	twiddle_powers u_pow (
		.clk(clk), .rst_n(rst_n), .w1_real(w1_real), .w1_imag(w1_imag),
		.factor(fac_cordic), .coef(coeff_if.source)
	);

	twiddle_mult u_mult (
		.clk(clk), .rst_n(rst_n), .in_val(in_val), .twdl_den(twdl_den),
		.din_real(din_real), .din_imag(din_imag),
		.fifo_q_real(fifo_q_real), .fifo_q_imag(fifo_q_imag),
		.coef(coeff_if.sink), .fifo_rd(fifo_rd), .fifo_clr(fifo_clr),
		.out_val(out_val), .dout_real(dout_real), .dout_imag(dout_imag)
	);

endmodule

// File: verilog/twiddle_mult.sv
`timescale 1ns/100ps
`include "twiddle_params.svh"

module twiddle_mult (
	input logic clk,
	input logic rst_n,
	input logic in_val,
	input twiddle_pkg::frac_t twdl_den,
	input twiddle_pkg::sample_t din_real [0:4],
	input twiddle_pkg::sample_t din_imag [0:4],
	input twiddle_pkg::sample_t fifo_q_real [0:4],
	input twiddle_pkg::sample_t fifo_q_imag [0:4],
	twiddle_if.sink coef,
	output logic fifo_rd,
	output logic fifo_clr,
	output logic out_val,
	output twiddle_pkg::sample_t dout_real [0:4],
	output twiddle_pkg::sample_t dout_imag [0:4]
);
	import twiddle_pkg::*;

	localparam int WP = `W_SAMPLE + `W_COEF;

	// bit k high k+1 cycles after in_val
	logic [`TWDL_DELAY-1:0] valid_r;
	logic bypass;
	logic res_val;
	sample_t d_r [0:4];
	sample_t d_i [0:4];
	sample_t lane0_r, lane0_i;
	logic signed [WP-1:0] prod_r [1:4];
	logic signed [WP-1:0] prod_i [1:4];

	// q14 product back to 18 bits, half up
	function automatic sample_t round_q14(input logic signed [WP-1:0] v);
		return v[`W_SAMPLE+13:14] + sample_t'(v[13]);
	endfunction

	assign bypass = (twdl_den == `BYPASS_DEN);
	assign res_val = valid_r[`TWDL_DELAY-2];

	always_ff @(posedge clk) begin
		if (!rst_n)
			valid_r <= '0;
		else
			valid_r <= {valid_r[`TWDL_DELAY-2:0], in_val};
	end

	// pop at delay-3 so data meets the aligned coefficients
	// bypass drains the fifo one cycle behind the write
	assign fifo_rd = bypass ? valid_r[0] : valid_r[`TWDL_DELAY-4];
	// clear after the last read, only once nothing is pending
	assign fifo_clr = valid_r[`TWDL_DELAY-3] & ~valid_r[`TWDL_DELAY-4]
		& ~(|valid_r[`TWDL_DELAY-5:0]) & ~in_val;

	// fifo head registered once
	always_ff @(posedge clk) begin
		for (int n = 0; n < 5; n++) begin
			d_r[n] <= fifo_q_real[n];
			d_i[n] <= fifo_q_imag[n];
		end
	end

	// complex product, lanes 1..4
	always_ff @(posedge clk) begin
		for (int n = 1; n < 5; n++) begin
			prod_r[n] <= d_r[n] * coef.w_real[n] - d_i[n] * coef.w_imag[n];
			prod_i[n] <= d_r[n] * coef.w_imag[n] + d_i[n] * coef.w_real[n];
		end
		lane0_r <= d_r[0];
		lane0_i <= d_i[0];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_val <= 1'b0;
			for (int n = 0; n < 5; n++) begin
				dout_real[n] <= '0;
				dout_imag[n] <= '0;
			end
		end else if (bypass) begin
			out_val <= in_val;
			dout_real[0] <= in_val ? din_real[0] : '0;
			dout_imag[0] <= in_val ? din_imag[0] : '0;
			// unity twiddle, scale by 2^14 then round
			for (int n = 1; n < 5; n++) begin
				dout_real[n] <= in_val ? round_q14({{2{din_real[n][`W_SAMPLE-1]}},
					din_real[n], 14'b0}) : '0;
				dout_imag[n] <= in_val ? round_q14({{2{din_imag[n][`W_SAMPLE-1]}},
					din_imag[n], 14'b0}) : '0;
			end
		end else begin
			out_val <= res_val;
			dout_real[0] <= res_val ? lane0_r : '0;
			dout_imag[0] <= res_val ? lane0_i : '0;
			for (int n = 1; n < 5; n++) begin
				dout_real[n] <= res_val ? round_q14(prod_r[n]) : '0;
				dout_imag[n] <= res_val ? round_q14(prod_i[n]) : '0;
			end
		end
	end

	// every result traces back to a strobe, one cycle or full delay earlier
	a_val_origin: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(out_val) |-> ($past(in_val) || $past(in_val, `TWDL_DELAY)));

endmodule

// File: verilog/twiddle_powers.sv
`timescale 1ns/100ps
`include "twiddle_params.svh"

module twiddle_powers (
	input logic clk,
	input logic rst_n,
	input twiddle_pkg::coef_t w1_real,
	input twiddle_pkg::coef_t w1_imag,
	input twiddle_pkg::factor_t factor,
	twiddle_if.source coef
);
	import twiddle_pkg::*;

	localparam int WP = 2 * `W_COEF;

	coef_t a_r, a_i;
	coef_t b_r, b_i;
	coef_t c1_r, c1_i;
	coef_t c2_r, c2_i;
	logic signed [WP-1:0] sq_rr, sq_ii, sq_ri;
	logic signed [WP-1:0] sq2_r;
	factor_t f1, f2, f3;

	// stage 1, capture w1
	always_ff @(posedge clk) begin
		a_r <= w1_real;
		a_i <= w1_imag;
	end

	// stage 2, products for w2
	always_ff @(posedge clk) begin
		sq_rr <= a_r * a_r;
		sq_ii <= a_i * a_i;
		sq_ri <= a_r * a_i;
		b_r <= a_r;
		b_i <= a_i;
	end

	assign sq2_r = sq_rr - sq_ii;

	// stage 3, w2 with factor-2 unity substitution
	always_ff @(posedge clk) begin
		if (f2 == 3'd2) begin
			c2_r <= coef_t'(16384);
			c2_i <= '0;
		end else begin
			c2_r <= sq2_r[29:14];
			// single cross product, taken one bit lower to double it
			c2_i <= sq_ri[28:13];
		end
		c1_r <= b_r;
		c1_i <= b_i;
	end

	// stage 4, w3 = w1*w2, w4 = w2^2, w1 and w2 delay-aligned
	always_ff @(posedge clk) begin
		logic signed [WP-1:0] t3_r, t3_i, t4_r, t4_i;
		t3_r = c1_r * c2_r - c1_i * c2_i;
		t3_i = c1_r * c2_i + c1_i * c2_r;
		t4_r = c2_r * c2_r - c2_i * c2_i;
		t4_i = c2_r * c2_i;
		coef.w_real[1] <= c1_r;
		coef.w_imag[1] <= c1_i;
		coef.w_real[2] <= c2_r;
		coef.w_imag[2] <= c2_i;
		// radix 2 reuses w1 for the third lane
		coef.w_real[3] <= (f3 == 3'd2) ? c1_r : t3_r[29:14];
		coef.w_imag[3] <= (f3 == 3'd2) ? c1_i : t3_i[29:14];
		coef.w_real[4] <= t4_r[29:14];
		coef.w_imag[4] <= t4_i[28:13];
	end

	// factor follows the data through stages 1 to 3
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			f1 <= '0;
			f2 <= '0;
			f3 <= '0;
		end else begin
			f1 <= factor;
			f2 <= f1;
			f3 <= f2;
		end
	end

endmodule

// File: verilog/cordic_sincos.sv
`timescale 1ns/100ps
`include "twiddle_params.svh"

module cordic_sincos (
	input logic clk,
	input logic rst_n,
	input twiddle_pkg::phase_t phase,
	input twiddle_pkg::factor_t factor_in,
	output twiddle_pkg::factor_t factor_out,
	output twiddle_pkg::coef_t w1_real,
	output twiddle_pkg::coef_t w1_imag
);
	import twiddle_pkg::*;

	// two guard bits over the coefficient width
	localparam int WX = `W_COEF + 2;
	localparam int WZ = `W_PHASE + 1;

	logic signed [WX-1:0] x_p [0:`CORDIC_ITER];
	logic signed [WX-1:0] y_p [0:`CORDIC_ITER];
	logic signed [WZ-1:0] z_p [0:`CORDIC_ITER];
	factor_t fac_p [0:`CORDIC_ITER];

	// quadrant fold: start vector pre-rotated by 0/90/180/270 degrees
	always_ff @(posedge clk) begin
		case (phase[`W_PHASE-1 -: 2])
			2'd0: begin
				x_p[0] <= WX'(`CORDIC_GAIN_INIT);
				y_p[0] <= '0;
			end
			2'd1: begin
				x_p[0] <= '0;
				y_p[0] <= WX'(`CORDIC_GAIN_INIT);
			end
			2'd2: begin
				x_p[0] <= -WX'(`CORDIC_GAIN_INIT);
				y_p[0] <= '0;
			end
			default: begin
				x_p[0] <= '0;
				y_p[0] <= -WX'(`CORDIC_GAIN_INIT);
			end
		endcase
		// residual angle below a quarter turn
		z_p[0] <= WZ'(phase[`W_PHASE-3:0]);
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			fac_p[0] <= '0;
		else
			fac_p[0] <= factor_in;
	end

	genvar k;
	generate
		for (k = 0; k < `CORDIC_ITER; k++) begin : g_iter
			// rotate toward zero residual angle
			always_ff @(posedge clk) begin
				if (!z_p[k][WZ-1]) begin
					x_p[k+1] <= x_p[k] - (y_p[k] >>> k);
					y_p[k+1] <= y_p[k] + (x_p[k] >>> k);
					z_p[k+1] <= z_p[k] - WZ'(atan_table[k]);
				end else begin
					x_p[k+1] <= x_p[k] + (y_p[k] >>> k);
					y_p[k+1] <= y_p[k] - (x_p[k] >>> k);
					z_p[k+1] <= z_p[k] + WZ'(atan_table[k]);
				end
			end

			always_ff @(posedge clk) begin
				if (!rst_n)
					fac_p[k+1] <= '0;
				else
					fac_p[k+1] <= fac_p[k];
			end
		end
	endgenerate

	// exp(-j theta): cosine and negated sine
	assign w1_real = coef_t'(x_p[`CORDIC_ITER]);
	assign w1_imag = coef_t'(-y_p[`CORDIC_ITER]);
	assign factor_out = fac_p[`CORDIC_ITER];

endmodule

// File: verilog/phase_divider.sv
`timescale 1ns/100ps
`include "twiddle_params.svh"

module phase_divider (
	input logic clk,
	input logic rst_n,
	input twiddle_pkg::frac_t num,
	input twiddle_pkg::frac_t den,
	input twiddle_pkg::factor_t factor_in,
	output twiddle_pkg::phase_t phase,
	output twiddle_pkg::factor_t factor_out
);
	import twiddle_pkg::*;

	// index 0 is the unregistered input
	frac_t rem_p [0:`DIV_LAT];
	frac_t den_p [0:`DIV_LAT];
	phase_t quo_p [0:`DIV_LAT];
	factor_t fac_p [0:`DIV_LAT];

	assign rem_p[0] = num;
	assign den_p[0] = den;
	assign quo_p[0] = '0;
	assign fac_p[0] = factor_in;

	genvar s;
	generate
		for (s = 0; s < `DIV_LAT; s++) begin : g_stage
			// partial remainder doubled for one quotient bit per stage
			logic [`W_FRAC:0] shifted;
			logic take;

			assign shifted = {rem_p[s], 1'b0};
			assign take = (shifted >= {1'b0, den_p[s]});

			always_ff @(posedge clk) begin
				if (take)
					rem_p[s+1] <= frac_t'(shifted - {1'b0, den_p[s]});
				else
					rem_p[s+1] <= shifted[`W_FRAC-1:0];
				quo_p[s+1] <= {quo_p[s][`W_PHASE-2:0], take};
				den_p[s+1] <= den_p[s];
			end

			// factor rides along with the division
			always_ff @(posedge clk) begin
				if (!rst_n)
					fac_p[s+1] <= '0;
				else
					fac_p[s+1] <= fac_p[s];
			end
		end
	endgenerate

	assign phase = quo_p[`DIV_LAT];
	assign factor_out = fac_p[`DIV_LAT];

	// a zero divisor entering the pipe gives a garbage phase
	a_den_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		den != '0);

endmodule

// File: verilog/lane_fifo.sv
`timescale 1ns/100ps
`include "twiddle_params.svh"

module lane_fifo (
	input logic clk,
	input logic rst_n,
	input logic wr,
	input twiddle_pkg::sample_t wdata [0:1],
	input logic rd,
	input logic clr,
	output twiddle_pkg::sample_t rdata [0:1]
);
	import twiddle_pkg::*;

	localparam int AW = $clog2(`FIFO_DEPTH);

	// real and imag packed side by side
	logic [2*`W_SAMPLE-1:0] mem [0:`FIFO_DEPTH-1];
	// extra msb tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic empty;
	logic full;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	always_ff @(posedge clk) begin
		if (!rst_n || clr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_ptr[AW-1:0]] <= {wdata[0], wdata[1]};
	end

	// show-ahead, head entry visible before the read
	assign rdata[0] = sample_t'(mem[rd_ptr[AW-1:0]][2*`W_SAMPLE-1:`W_SAMPLE]);
	assign rdata[1] = sample_t'(mem[rd_ptr[AW-1:0]][`W_SAMPLE-1:0]);

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		rd && !clr |-> !empty);
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		wr && !clr && !rd |-> !full);

endmodule

// File: verilog/twiddle_if.sv
`timescale 1ns/100ps
`include "twiddle_params.svh"

interface twiddle_if;

	// powers 1..4 of the base twiddle, all aligned
	twiddle_pkg::coef_t w_real [1:4];
	twiddle_pkg::coef_t w_imag [1:4];

	modport source (
		output w_real,
		output w_imag
	);

	modport sink (
		input w_real,
		input w_imag
	);

endinterface

// File: verilog/twiddle_pkg.sv
`include "twiddle_params.svh"

package twiddle_pkg;

	// lane sample component, 1.17
	typedef logic signed [`W_SAMPLE-1:0] sample_t;
	// twiddle component, Q2.14
	typedef logic signed [`W_COEF-1:0] coef_t;
	// numerator / denominator
	typedef logic [`W_FRAC-1:0] frac_t;
	// fraction of a full turn
	typedef logic [`W_PHASE-1:0] phase_t;
	typedef logic [2:0] factor_t;

	// atan(2^-k) in units of 2^-16 turn
	localparam phase_t atan_table [0:`CORDIC_ITER-1] = '{
		16'd8192, 16'd4836, 16'd2555, 16'd1297,
		16'd651, 16'd326, 16'd163, 16'd81,
		16'd41, 16'd20, 16'd10, 16'd5,
		16'd3, 16'd1
	};

endpackage

// File: verilog/twiddle_params.svh
`ifndef TWIDDLE_PARAMS_SVH
`define TWIDDLE_PARAMS_SVH

// datapath widths
`define W_SAMPLE 18
`define W_COEF 16
`define W_FRAC 12
`define W_PHASE 16
`define CORDIC_ITER 14

// pipeline latencies in cycles
`define DIV_LAT 16
`define CORDIC_LAT 15
`define POW_LAT 4
// coefficient path plus multiply and output register
`define TWDL_DELAY 37

// last stage of the transform, no rotation
`define BYPASS_DEN 3
// 16384 / 1.647
`define CORDIC_GAIN_INIT 9948
`define FIFO_DEPTH 64

`endif
